// ==== logic/spi_host_params.svh ====
/*
 * SPI host parameter macros
 *   divider and byte count widths
 *   configuration register addresses
 */
`ifndef SPI_HOST_PARAMS_SVH
`define SPI_HOST_PARAMS_SVH

// serial clock half-period is divider + 1 system clocks
`define SPI_CLKDIV_W 8

// programmed length L moves L + 1 bytes
`define SPI_LEN_W 8

// register map on a 2-bit address
`define SPI_ADDR_CTRL 2'd0
`define SPI_ADDR_DIV  2'd1
`define SPI_ADDR_LEN  2'd2

`endif

// ==== logic/spi_host_pkg.sv ====
/*
 * SPI host package
 *   vector typedefs for bytes, lanes, divider, length and address
 *   speed and FSM state enums, configuration struct
 */
`default_nettype none

`include "spi_host_params.svh"

package spi_host_pkg;

  typedef logic [7:0]                 spi_byte_t;
  typedef logic [3:0]                 sd_lanes_t;
  typedef logic [`SPI_CLKDIV_W-1:0]   clkdiv_t;
  typedef logic [`SPI_LEN_W-1:0]      len_t;
  typedef logic [1:0]                 reg_addr_t;

  // lanes used per bit group
  typedef enum logic [1:0] {
    Standard = 2'd0,
    Dual     = 2'd1,
    Quad     = 2'd2,
    RsvdSpd  = 2'd3
  } speed_e;

  // register block to FSM and shift register
  typedef struct packed {
    speed_e  speed;
    clkdiv_t clkdiv;
    len_t    len;
  } spi_cfg_t;

  typedef enum logic [2:0] {
    Idle,
    CsSetup,
    SckLow,
    SckHigh,
    ByteWait,
    CsHold
  } fsm_state_e;

endpackage

`default_nettype wire

// ==== logic/spi_host_cfg_regs.sv ====
/*
 * SPI host configuration registers
 *   four-phase req/ack access port
 *   speed, divider and length fields, start and soft-reset pulses
 */
`timescale 1ns/10ps
`default_nettype none

`include "spi_host_params.svh"

module spi_host_cfg_regs import spi_host_pkg::*; (
  input  wire            clk_i,
  input  wire            rst_ni,
  input  wire            cfg_req_i,
  input  wire            cfg_we_i,
  input  wire reg_addr_t cfg_addr_i,
  input  wire [15:0]     cfg_wdata_i,
  output logic           cfg_ack_o,
  output logic [15:0]    cfg_rdata_o,
  input  wire            busy_i,
  output spi_cfg_t       cfg_o,
  output logic           start_o,
  output logic           sw_rst_o
);

  typedef enum logic {
    HsIdle,
    HsAck
  } hs_state_e;

  hs_state_e hs_q;
  speed_e    speed_q;
  clkdiv_t   div_q;
  len_t      len_q;
  logic      access;
  logic      ctrl_wr;
  speed_e    wr_speed;

  // one access per request, taken only while ack is low
  assign access    = (hs_q == HsIdle) && cfg_req_i;
  assign ctrl_wr   = access && cfg_we_i && (cfg_addr_i == `SPI_ADDR_CTRL);
  assign wr_speed  = speed_e'(cfg_wdata_i[3:2]);
  assign cfg_ack_o = (hs_q == HsAck);
  assign cfg_o     = '{speed: speed_q, clkdiv: div_q, len: len_q};

  // ack stays up until req is seen low
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      hs_q <= HsIdle;
    end else if (access) begin
      hs_q <= HsAck;
    end else if ((hs_q == HsAck) && !cfg_req_i) begin
      hs_q <= HsIdle;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      speed_q  <= Standard;
      div_q    <= '0;
      len_q    <= '0;
      start_o  <= 1'b0;
      sw_rst_o <= 1'b0;
    end else begin
      // reserved speed code keeps the old speed
      if (ctrl_wr && (wr_speed != RsvdSpd)) begin
        speed_q <= wr_speed;
      end
      if (access && cfg_we_i && (cfg_addr_i == `SPI_ADDR_DIV)) begin
        div_q <= cfg_wdata_i[`SPI_CLKDIV_W-1:0];
      end
      if (access && cfg_we_i && (cfg_addr_i == `SPI_ADDR_LEN)) begin
        len_q <= cfg_wdata_i[`SPI_LEN_W-1:0];
      end
      // soft reset wins over a start in the same write
      start_o  <= ctrl_wr && cfg_wdata_i[0] && !cfg_wdata_i[1] && !busy_i;
      sw_rst_o <= ctrl_wr && cfg_wdata_i[1];
    end
  end

  always_ff @(posedge clk_i) begin
    if (access && !cfg_we_i) begin
      case (cfg_addr_i)
        `SPI_ADDR_CTRL: cfg_rdata_o <= {11'd0, busy_i, speed_q, 2'b00};
        `SPI_ADDR_DIV:  cfg_rdata_o <= {{(16-`SPI_CLKDIV_W){1'b0}}, div_q};
        `SPI_ADDR_LEN:  cfg_rdata_o <= {{(16-`SPI_LEN_W){1'b0}}, len_q};
        default:        cfg_rdata_o <= '0;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== logic/spi_host_fsm.sv ====
/*
 * SPI host timing and control FSM
 *   half-period divider, chip select and mode 0 serial clock
 *   bit group and byte counting, stall at byte boundaries
 */
`timescale 1ns/10ps
`default_nettype none

module spi_host_fsm import spi_host_pkg::*; (
  input  wire           clk_i,
  input  wire           rst_ni,
  input  wire spi_cfg_t cfg_i,
  input  wire           start_i,
  input  wire           sw_rst_i,
  output logic          busy_o,
  output logic          sck_o,
  output logic          csb_o,
  output logic          wr_en_o,
  input  wire           wr_ready_i,
  output logic          rd_en_o,
  input  wire           rd_ready_i,
  output logic          shift_en_o,
  output logic          sample_en_o,
  output logic          full_cyc_o,
  output logic          last_read_o
);

  fsm_state_e state_q, state_d;
  clkdiv_t    div_cnt_q, div_cnt_d;
  logic [2:0] grp_cnt_q, grp_cnt_d;
  logic [2:0] grp_last;
  len_t       byte_cnt_q, byte_cnt_d;
  logic       rd_pend_q, rd_pend_d;
  logic       timed;
  logic       tick;
  logic       last_byte;
  logic       rd_clear;

  // last bit group index: 8, 4 or 2 groups per byte
  always_comb begin
    case (cfg_i.speed)
      Dual:    grp_last = 3'd3;
      Quad:    grp_last = 3'd1;
      default: grp_last = 3'd7;
    endcase
  end

  // states that last one half-period
  assign timed = (state_q == CsSetup) || (state_q == SckLow) ||
                 (state_q == SckHigh) || (state_q == CsHold);
  assign tick  = timed && (div_cnt_q == cfg_i.clkdiv);
  assign div_cnt_d = (timed && !tick && !sw_rst_i) ? div_cnt_q + 1'b1 : '0;

  assign last_byte   = (byte_cnt_q == cfg_i.len);
  assign rd_clear    = !rd_pend_q || rd_ready_i;
  assign busy_o      = (state_q != Idle);
  assign csb_o       = (state_q == Idle);
  assign sck_o       = (state_q == SckHigh);
  assign last_read_o = last_byte;
  // half-cycle sampling only
  assign full_cyc_o  = 1'b0;

  always_comb begin
    state_d     = state_q;
    grp_cnt_d   = grp_cnt_q;
    byte_cnt_d  = byte_cnt_q;
    rd_pend_d   = rd_pend_q;
    wr_en_o     = 1'b0;
    rd_en_o     = 1'b0;
    shift_en_o  = 1'b0;
    sample_en_o = 1'b0;
    case (state_q)
      Idle: begin
        grp_cnt_d  = '0;
        byte_cnt_d = '0;
        rd_pend_d  = 1'b0;
        if (start_i) begin
          state_d = CsSetup;
        end
      end
      CsSetup: begin
        if (tick) begin
          state_d = ByteWait;
        end
      end
      SckLow: begin
        // rising edge, capture the input lanes
        if (tick) begin
          sample_en_o = 1'b1;
          state_d     = SckHigh;
        end
      end
      SckHigh: begin
        if (tick && (grp_cnt_q != grp_last)) begin
          shift_en_o = 1'b1;
          grp_cnt_d  = grp_cnt_q + 1'b1;
          state_d    = SckLow;
        end else if (tick && !rd_ready_i) begin
          // receive buffer full, hold the byte with sck low
          rd_pend_d = 1'b1;
          state_d   = ByteWait;
        end else if (tick) begin
          shift_en_o = 1'b1;
          rd_en_o    = 1'b1;
          byte_cnt_d = byte_cnt_q + 1'b1;
          if (last_byte) begin
            state_d = CsHold;
          end else begin
            wr_en_o   = 1'b1;
            grp_cnt_d = '0;
            state_d   = wr_ready_i ? SckLow : ByteWait;
          end
        end
      end
      ByteWait: begin
        if (rd_pend_q && rd_ready_i) begin
          rd_en_o    = 1'b1;
          rd_pend_d  = 1'b0;
          byte_cnt_d = byte_cnt_q + 1'b1;
        end
        if (rd_clear && rd_pend_q && last_byte) begin
          state_d = CsHold;
        end else if (rd_clear) begin
          // next transmit byte is needed
          wr_en_o   = 1'b1;
          grp_cnt_d = '0;
          if (wr_ready_i) begin
            state_d = SckLow;
          end
        end
      end
      CsHold: begin
        if (tick) begin
          state_d = Idle;
        end
      end
      default: begin
        state_d = Idle;
      end
    endcase
    if (sw_rst_i) begin
      state_d    = Idle;
      rd_pend_d  = 1'b0;
      wr_en_o    = 1'b0;
      rd_en_o    = 1'b0;
      shift_en_o = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= Idle;
      div_cnt_q  <= '0;
      grp_cnt_q  <= '0;
      byte_cnt_q <= '0;
      rd_pend_q  <= 1'b0;
    end else begin
      state_q    <= state_d;
      div_cnt_q  <= div_cnt_d;
      grp_cnt_q  <= grp_cnt_d;
      byte_cnt_q <= byte_cnt_d;
      rd_pend_q  <= rd_pend_d;
    end
  end

endmodule

`default_nettype wire

// ==== logic/spi_host_shift_register.sv ====
/*
 * SPI host shift register
 *   MSB-first shifting over 1, 2 or 4 lanes
 *   input lane sampling and a one-entry receive buffer with last flag
 */
`timescale 1ns/10ps
`default_nettype none

module spi_host_shift_register import spi_host_pkg::*; (
  input  wire            clk_i,
  input  wire            rst_ni,
  input  wire            wr_en_i,
  output logic           wr_ready_o,
  input  wire            rd_en_i,
  output logic           rd_ready_o,

  input  wire speed_e    speed_i,
  input  wire            shift_en_i,
  input  wire            sample_en_i,
  input  wire            full_cyc_i,
  input  wire            last_read_i,

  input  wire spi_byte_t tx_data_i,
  input  wire            tx_valid_i,
  output logic           tx_ready_o,

  output spi_byte_t      rx_data_o,
  output logic           rx_valid_o,
  input  wire            rx_ready_i,
  output logic           rx_last_o,

  input  wire sd_lanes_t sd_i,
  output sd_lanes_t      sd_o,

  input  wire            sw_rst_i
);

  spi_byte_t sr_q;
  spi_byte_t sr_shifted;
  sd_lanes_t sd_i_q;
  sd_lanes_t next_bits;
  spi_byte_t rx_buf_q;
  logic      rx_last_q;
  logic      rx_buf_valid_q;
  logic      rx_load;
  logic      rx_take;

  assign next_bits = full_cyc_i ? sd_i : sd_i_q;

  // standard mode drives lane 0 and receives on lane 1
  always_comb begin
    case (speed_i)
      Standard: begin
        sr_shifted = {sr_q[6:0], next_bits[1]};
        sd_o       = {3'b000, sr_q[7]};
      end
      Dual: begin
        sr_shifted = {sr_q[5:0], next_bits[1:0]};
        sd_o       = {2'b00, sr_q[7:6]};
      end
      Quad: begin
        sr_shifted = {sr_q[3:0], next_bits};
        sd_o       = sr_q[7:4];
      end
      default: begin
        sr_shifted = '0;
        sd_o       = '0;
      end
    endcase
  end

  // transmit side is unbuffered, the FSM pulls bytes straight from the stream
  assign wr_ready_o = tx_valid_i;
  assign tx_ready_o = wr_en_i;

  // buffer frees in the same cycle the consumer takes it
  assign rx_take    = rx_buf_valid_q && rx_ready_i;
  assign rd_ready_o = !rx_buf_valid_q || rx_take;
  assign rx_load    = rd_en_i && rd_ready_o;
  assign rx_valid_o = rx_buf_valid_q;
  assign rx_data_o  = rx_buf_q;
  assign rx_last_o  = rx_last_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sr_q           <= '0;
      sd_i_q         <= '0;
      rx_buf_valid_q <= 1'b0;
    end else if (sw_rst_i) begin
      sr_q           <= '0;
      sd_i_q         <= '0;
      rx_buf_valid_q <= 1'b0;
    end else begin
      // a new byte takes priority over the final shift
      if (wr_en_i && wr_ready_o) begin
        sr_q <= tx_data_i;
      end else if (shift_en_i) begin
        sr_q <= sr_shifted;
      end
      if (sample_en_i) begin
        sd_i_q <= sd_i;
      end
      if (rx_load) begin
        rx_buf_valid_q <= 1'b1;
      end else if (rx_take) begin
        rx_buf_valid_q <= 1'b0;
      end
    end
  end

  // received byte includes the bits sampled on the last rising edge
  always_ff @(posedge clk_i) begin
    if (rx_load) begin
      rx_buf_q  <= sr_shifted;
      rx_last_q <= last_read_i;
    end
  end

endmodule

`default_nettype wire

// ==== logic/spi_host_core.sv ====
/*
 * SPI host top level
 *   configuration registers, timing FSM and shift register
 */
`timescale 1ns/10ps
`default_nettype none

module spi_host_core import spi_host_pkg::*; (
  input  wire            clk_i,
  input  wire            rst_ni,

  input  wire            cfg_req_i,
  input  wire            cfg_we_i,
  input  wire reg_addr_t cfg_addr_i,
  input  wire [15:0]     cfg_wdata_i,
  output logic           cfg_ack_o,
  output logic [15:0]    cfg_rdata_o,

  input  wire spi_byte_t tx_data_i,
  input  wire            tx_valid_i,
  output logic           tx_ready_o,

  output spi_byte_t      rx_data_o,
  output logic           rx_valid_o,
  output logic           rx_last_o,
  input  wire            rx_ready_i,

  output logic           sck_o,
  output logic           csb_o,
  output sd_lanes_t      sd_o,
  input  wire sd_lanes_t sd_i
);

  spi_cfg_t cfg;
  logic     start;
  logic     sw_rst;
  logic     busy;
  logic     wr_en;
  logic     wr_ready;
  logic     rd_en;
  logic     rd_ready;
  logic     shift_en;
  logic     sample_en;
  logic     full_cyc;
  logic     last_read;

  spi_host_cfg_regs u_cfg_regs (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .cfg_req_i   (cfg_req_i),
    .cfg_we_i    (cfg_we_i),
    .cfg_addr_i  (cfg_addr_i),
    .cfg_wdata_i (cfg_wdata_i),
    .cfg_ack_o   (cfg_ack_o),
    .cfg_rdata_o (cfg_rdata_o),
    .busy_i      (busy),
    .cfg_o       (cfg),
    .start_o     (start),
    .sw_rst_o    (sw_rst)
  );

  spi_host_fsm u_fsm (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .cfg_i       (cfg),
    .start_i     (start),
    .sw_rst_i    (sw_rst),
    .busy_o      (busy),
    .sck_o       (sck_o),
    .csb_o       (csb_o),
    .wr_en_o     (wr_en),
    .wr_ready_i  (wr_ready),
    .rd_en_o     (rd_en),
    .rd_ready_i  (rd_ready),
    .shift_en_o  (shift_en),
    .sample_en_o (sample_en),
    .full_cyc_o  (full_cyc),
    .last_read_o (last_read)
  );

  spi_host_shift_register u_shift_reg (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .wr_en_i     (wr_en),
    .wr_ready_o  (wr_ready),
    .rd_en_i     (rd_en),
    .rd_ready_o  (rd_ready),
    .speed_i     (cfg.speed),
    .shift_en_i  (shift_en),
    .sample_en_i (sample_en),
    .full_cyc_i  (full_cyc),
    .last_read_i (last_read),
    .tx_data_i   (tx_data_i),
    .tx_valid_i  (tx_valid_i),
    .tx_ready_o  (tx_ready_o),
    .rx_data_o   (rx_data_o),
    .rx_valid_o  (rx_valid_o),
    .rx_ready_i  (rx_ready_i),
    .rx_last_o   (rx_last_o),
    .sd_i        (sd_i),
    .sd_o        (sd_o),
    .sw_rst_i    (sw_rst)
  );

endmodule

`default_nettype wire

// ==== tb/tb_clk_gen.sv ====
/*
 * testbench clock and reset
 *   4 ns clock, active-low reset held for 4 cycles
 */
`timescale 1ns/10ps
`default_nettype none

module tb_clk_gen (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #2 clk_o = ~clk_o;
  end

  initial begin
    rst_no = 1'b0;
    repeat (4) @(posedge clk_o);
    // release away from the active edge
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

`default_nettype wire

// ==== tb/spi_host_core_asserts.sv ====
/*
 * SPI host protocol assertions
 *   config handshake, chip select, serial clock and receive stream rules
 *   bound to the top level
 */
`timescale 1ns/10ps
`default_nettype none

module spi_host_core_asserts import spi_host_pkg::*; (
  input wire             clk_i,
  input wire             rst_ni,
  input wire             cfg_req_i,
  input wire             cfg_ack_o,
  input wire             csb_o,
  input wire             sck_o,
  input wire             rx_valid_o,
  input wire             rx_ready_i,
  input wire             rx_last_o,
  input wire spi_byte_t  rx_data_o,
  input wire fsm_state_e state_i
);

  // ack only ever answers a request
  ack_after_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(cfg_ack_o) |-> $past(cfg_req_i))
    else $error("cfg_ack_o rose without a request");

  // chip select ends a command only once its last byte is in the buffer
  csb_held_to_last: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(csb_o) |-> (!rx_valid_o || rx_last_o))
    else $error("csb_o rose before the last byte");

  // chip select leads every rising sck edge
  sck_only_selected: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(sck_o) |-> $past(!csb_o, 2))
    else $error("sck_o rose without csb_o low");

  // a stall at a byte boundary never leaves on a rising edge
  sck_low_stall: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (state_i == ByteWait) |=> !sck_o)
    else $error("sck_o high after a stall");

  rx_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (rx_valid_o && !rx_ready_i) |=>
      (!rx_valid_o || ($stable(rx_data_o) && $stable(rx_last_o))))
    else $error("receive byte changed while held");

endmodule

bind spi_host_core spi_host_core_asserts u_asserts (
  .clk_i      (clk_i),
  .rst_ni     (rst_ni),
  .cfg_req_i  (cfg_req_i),
  .cfg_ack_o  (cfg_ack_o),
  .csb_o      (csb_o),
  .sck_o      (sck_o),
  .rx_valid_o (rx_valid_o),
  .rx_ready_i (rx_ready_i),
  .rx_last_o  (rx_last_o),
  .rx_data_o  (rx_data_o),
  .state_i    (u_fsm.state_q)
);

`default_nettype wire

// ==== tb/spi_host_core_tb.sv ====
/*
 * SPI host testbench
 *   loopback of sd_o into sd_i, command table, config and stream drivers
 *   compare tasks, cycle timeout and closing status
 */
`timescale 1ns/10ps
`default_nettype none

`include "spi_host_params.svh"

module spi_host_core_tb import spi_host_pkg::*; ();

  typedef struct packed {
    speed_e  speed;
    clkdiv_t div;
    len_t    len;
    logic    stall;
  } cmd_t;

  localparam int NumCmds = 8;

  logic        clk;
  logic        rst_n;
  logic        cfg_req;
  logic        cfg_we;
  reg_addr_t   cfg_addr;
  logic [15:0] cfg_wdata;
  logic        cfg_ack;
  logic [15:0] cfg_rdata;
  spi_byte_t   tx_data;
  logic        tx_valid;
  logic        tx_ready;
  spi_byte_t   rx_data;
  logic        rx_valid;
  logic        rx_last;
  logic        rx_ready;
  logic        sck;
  logic        csb;
  sd_lanes_t   sd_o;
  sd_lanes_t   sd_i;
  logic        lb_std;
  logic        stall_mode;
  cmd_t        cmds [NumCmds];
  spi_byte_t   tx_q [$];
  spi_byte_t   exp_q [$];
  int          sck_rises;
  int          mismatches;
  int          other_errs;
  int          cycles;
  int          cycle_limit;

  // standard speed sends on lane 0 and receives on lane 1
  assign sd_i = lb_std ? {2'b00, sd_o[0], 1'b0} : sd_o;

  tb_clk_gen u_clk_gen (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  spi_host_core spi_host_core_i (
    .clk_i       (clk),
    .rst_ni      (rst_n),
    .cfg_req_i   (cfg_req),
    .cfg_we_i    (cfg_we),
    .cfg_addr_i  (cfg_addr),
    .cfg_wdata_i (cfg_wdata),
    .cfg_ack_o   (cfg_ack),
    .cfg_rdata_o (cfg_rdata),
    .tx_data_i   (tx_data),
    .tx_valid_i  (tx_valid),
    .tx_ready_o  (tx_ready),
    .rx_data_o   (rx_data),
    .rx_valid_o  (rx_valid),
    .rx_last_o   (rx_last),
    .rx_ready_i  (rx_ready),
    .sck_o       (sck),
    .csb_o       (csb),
    .sd_o        (sd_o),
    .sd_i        (sd_i)
  );

  task automatic check_byte(input string name, input spi_byte_t got, input spi_byte_t exp);
    if (got !== exp) begin
      mismatches++;
      $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      mismatches++;
      $display("Mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic check_word(input string name, input logic [15:0] got, input logic [15:0] exp);
    if (got !== exp) begin
      mismatches++;
      $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  // full four-phase access, ack expected one cycle after req
  task automatic cfg_access(input logic we, input reg_addr_t addr, input logic [15:0] wdata,
                            output logic [15:0] rdata);
    int waited;
    @(negedge clk);
    cfg_req   = 1'b1;
    cfg_we    = we;
    cfg_addr  = addr;
    cfg_wdata = wdata;
    waited    = 0;
    do begin
      @(negedge clk);
      waited++;
    end while (!cfg_ack && waited < 20);
    if (!cfg_ack) begin
      other_errs++;
      $display("Error at %0t: no cfg_ack_o for request to address %0d", $time, addr);
    end else if (waited != 1) begin
      other_errs++;
      $display("Error at %0t: cfg_ack_o came %0d cycles after req", $time, waited);
    end
    rdata   = cfg_rdata;
    cfg_req = 1'b0;
    waited  = 0;
    do begin
      @(negedge clk);
      waited++;
    end while (cfg_ack && waited < 20);
    if (cfg_ack) begin
      other_errs++;
      $display("Error at %0t: cfg_ack_o stuck high after req dropped", $time);
    end else if (waited != 1) begin
      other_errs++;
      $display("Error at %0t: cfg_ack_o fell %0d cycles after req dropped", $time, waited);
    end
  endtask

  task automatic cfg_write(input reg_addr_t addr, input logic [15:0] wdata);
    logic [15:0] unused;
    cfg_access(1'b1, addr, wdata, unused);
  endtask

  task automatic cfg_read_check(input string name, input reg_addr_t addr,
                                input logic [15:0] exp);
    logic [15:0] rd;
    cfg_access(1'b0, addr, 16'h0000, rd);
    check_word(name, rd, exp);
  endtask

  task automatic start_cmd(input cmd_t c);
    spi_byte_t b;
    lb_std     = (c.speed == Standard);
    stall_mode = c.stall;
    cfg_write(`SPI_ADDR_DIV, {8'd0, c.div});
    cfg_write(`SPI_ADDR_LEN, {8'd0, c.len});
    for (int i = 0; i <= int'(c.len); i++) begin
      b = spi_byte_t'($urandom);
      tx_q.push_back(b);
      exp_q.push_back(b);
    end
    sck_rises = 0;
    cfg_write(`SPI_ADDR_CTRL, {12'd0, c.speed, 2'b01});
  endtask

  task automatic finish_cmd(input cmd_t c);
    int lanes;
    lanes = (c.speed == Quad) ? 4 : (c.speed == Dual) ? 2 : 1;
    while (exp_q.size() != 0 || !csb) begin
      @(negedge clk);
    end
    check_word("sck rising edges", 16'(sck_rises), 16'((int'(c.len) + 1) * 8 / lanes));
    check_word("tx bytes left", 16'(tx_q.size()), 16'd0);
    // busy low and speed kept
    cfg_read_check("ctrl after command", `SPI_ADDR_CTRL, {12'd0, c.speed, 2'b00});
    stall_mode = 1'b0;
  endtask

  function automatic int cycle_budget();
    int sum;
    sum = 0;
    for (int i = 0; i < NumCmds; i++) begin
      sum += (int'(cmds[i].len) + 1) * 8 * 2 * (int'(cmds[i].div) + 1);
    end
    return sum * 4 + 5000;
  endfunction

  // stream side, values settle before the sampling edge
  always @(negedge clk) begin
    spi_byte_t exp_b;
    if (rst_n) begin
      tx_valid = (tx_q.size() > 0) && (!stall_mode || ($urandom_range(3, 0) != 0));
      tx_data  = tx_valid ? tx_q[0] : 8'h00;
      rx_ready = !stall_mode || ($urandom_range(2, 0) != 0);
      #1;
      if (tx_valid && tx_ready) begin
        void'(tx_q.pop_front());
      end
      if (rx_valid && rx_ready) begin
        if (exp_q.size() == 0) begin
          other_errs++;
          $display("Error at %0t: receive byte %h arrived with none expected", $time, rx_data);
        end else begin
          exp_b = exp_q.pop_front();
          check_byte("rx_data_o", rx_data, exp_b);
          check_flag("rx_last_o", rx_last, exp_q.size() == 0);
        end
      end
    end
  end

  always @(posedge sck) begin
    if (!csb) begin
      sck_rises++;
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > cycle_limit) begin
      $display("Error: run timed out after %0d cycles", cycles);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  initial begin
    cmd_t sr_cmd;
    cfg_req    = 1'b0;
    cfg_we     = 1'b0;
    cfg_addr   = '0;
    cfg_wdata  = '0;
    tx_data    = '0;
    tx_valid   = 1'b0;
    rx_ready   = 1'b1;
    lb_std     = 1'b1;
    stall_mode = 1'b0;
    mismatches = 0;
    other_errs = 0;
    cycles     = 0;
    sck_rises  = 0;
    void'($urandom(32'h6cde));
    cmds[0] = '{Standard, 8'd0, 8'd3, 1'b0};
    cmds[1] = '{Standard, 8'd2, 8'd2, 1'b0};
    cmds[2] = '{Dual,     8'd1, 8'd4, 1'b0};
    cmds[3] = '{Dual,     8'd3, 8'd1, 1'b0};
    cmds[4] = '{Quad,     8'd0, 8'd5, 1'b0};
    cmds[5] = '{Quad,     8'd2, 8'd3, 1'b1};
    cmds[6] = '{Standard, 8'd1, 8'd4, 1'b1};
    cmds[7] = '{Dual,     8'd0, 8'd6, 1'b1};
    cycle_limit = cycle_budget();
    @(posedge rst_n);
    check_flag("csb_o after reset", csb, 1'b1);
    check_flag("sck_o after reset", sck, 1'b0);
    check_flag("rx_valid_o after reset", rx_valid, 1'b0);

    // register access, reserved speed is refused
    cfg_write(`SPI_ADDR_DIV, 16'hab5a);
    cfg_read_check("div readback", `SPI_ADDR_DIV, 16'hab5a & 16'h00ff);
    cfg_write(`SPI_ADDR_LEN, 16'h00c3);
    cfg_read_check("len readback", `SPI_ADDR_LEN, 16'h00c3);
    cfg_write(`SPI_ADDR_CTRL, {12'd0, Quad, 2'b00});
    cfg_read_check("ctrl speed", `SPI_ADDR_CTRL, {12'd0, Quad, 2'b00});
    cfg_write(`SPI_ADDR_CTRL, {12'd0, RsvdSpd, 2'b00});
    cfg_read_check("ctrl reserved speed", `SPI_ADDR_CTRL, {12'd0, Quad, 2'b00});

    for (int i = 0; i < NumCmds; i++) begin
      start_cmd(cmds[i]);
      finish_cmd(cmds[i]);
    end

    // soft reset in the middle of a stalled command
    sr_cmd = '{Standard, 8'd3, 8'd7, 1'b1};
    start_cmd(sr_cmd);
    while (exp_q.size() > 5) begin
      @(negedge clk);
    end
    cfg_write(`SPI_ADDR_CTRL, {12'd0, sr_cmd.speed, 2'b10});
    tx_q.delete();
    exp_q.delete();
    stall_mode = 1'b0;
    check_flag("csb_o after soft reset", csb, 1'b1);
    check_flag("rx_valid_o after soft reset", rx_valid, 1'b0);
    cfg_read_check("ctrl after soft reset", `SPI_ADDR_CTRL, {12'd0, sr_cmd.speed, 2'b00});
    start_cmd(cmds[0]);
    finish_cmd(cmds[0]);

    $display("errors: %0d mismatches, %0d other", mismatches, other_errs);
    if (mismatches + other_errs == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== spi_host_core.f ====
+incdir+logic
logic/spi_host_pkg.sv
logic/spi_host_cfg_regs.sv
logic/spi_host_fsm.sv
logic/spi_host_shift_register.sv
logic/spi_host_core.sv
tb/tb_clk_gen.sv
tb/spi_host_core_asserts.sv
tb/spi_host_core_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = spi_host_core_tb
FILELIST  = spi_host_core.f
OBJDIR    = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1 || echo "STATUS: FAIL" >> $(LOG)
	cat $(LOG)
	! grep -q "STATUS: FAIL" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
